// File: Makefile
VERILATOR  ?= verilator
TOP        := tbClkDiagCtrl
RTL_TOP    := clkDiagCtrl
FILELIST   := src.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

# Lint the whole project from the testbench down
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run and search the log for the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/apbDiagPort.sv
`timescale 1ns/1ps
`default_nettype none

module apbDiagPort (
  input  logic                               PSEL,
  input  logic                               PENABLE,
  input  logic                               PWRITE,
  input  logic [clkDiagPkg::APB_ADDR_W-1:0]  PADDR,
  input  logic [clkDiagPkg::APB_DATA_W-1:0]  PWDATA,
  output logic [clkDiagPkg::APB_DATA_W-1:0]  PRDATA,
  output clkDiagPkg::diagCmd_t               cmd,
  input  logic [clkDiagPkg::DIAG_W-1:0]      rdWord
);

  import clkDiagPkg::*;

  logic accessPhase;
  logic writeAccess;
  logic ldRegion;

  // Access phase is always the second cycle of a transfer
  assign accessPhase = PSEL & PENABLE;
  assign writeAccess = accessPhase & PWRITE;

  // Top address bit splits 00x from 04x
  assign ldRegion = PADDR[APB_ADDR_W-1];

  always_comb begin
    cmd.ctlWrite    = writeAccess & ~ldRegion;
    cmd.ldWrite     = writeAccess & ldRegion;
    cmd.sel         = PADDR[SEL_W-1:0];
    cmd.data.nibble = PWDATA[NIBBLE_W-1:0];  // Blocks pick their own view
  end

  // Readback in the low bits with zeros above
  assign PRDATA = {{(APB_DATA_W - DIAG_W){1'b0}}, rdWord};

endmodule

`default_nettype wire

// File: hdl/burstCounter.sv
`timescale 1ns/1ps
`default_nettype none

module burstCounter (
  input  logic                             CLK,
  input  logic                             FPGA_RESET,
  input  clkDiagPkg::diagCmd_t             cmd,
  input  logic                             burstStep,
  output logic [clkDiagPkg::BURST_W-1:0]   count,
  output logic                             countZero
);

  import clkDiagPkg::*;

  logic loadLo;
  logic loadHi;

  assign loadLo = cmd.ldWrite && (cmd.sel == LD_BURST_LO);  // 042
  assign loadHi = cmd.ldWrite && (cmd.sel == LD_BURST_HI);  // 043

  assign countZero = (count == '0);

  // A nibble load wins over a step in the same cycle
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      count <= '0;
    end else if (loadLo) begin
      count[NIBBLE_W-1:0] <= cmd.data.nibble;
    end else if (loadHi) begin
      count[BURST_W-1:NIBBLE_W] <= cmd.data.nibble;
    end else if (burstStep && !countZero) begin
      count <= count - 1'b1;  // Stops at zero
    end
  end

endmodule

`default_nettype wire

// File: hdl/clkConfigRegs.sv
`timescale 1ns/1ps
`default_nettype none

module clkConfigRegs (
  input  logic                  CLK,
  input  logic                  FPGA_RESET,
  input  clkDiagPkg::diagCmd_t  cmd,
  output clkDiagPkg::clkCfg_t   cfg
);

  import clkDiagPkg::*;

  // Load functions 044 to 047
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      cfg <= '0;
    end else if (cmd.ldWrite) begin
      case (cmd.sel)
        LD_SRC_RATE: begin
          cfg.sourceSel <= cmd.data.srcRate.sourceSel;  // Read back only
          cfg.rateSel   <= cmd.data.srcRate.rateSel;
        end
        LD_EBOX_DIS: begin
          cfg.crmDis <= cmd.data.eboxDis.crmDis;
          cfg.edpDis <= cmd.data.eboxDis.edpDis;
          cfg.ctlDis <= cmd.data.eboxDis.ctlDis;
        end
        LD_PAR_CHK: begin
          cfg.fmParChk   <= cmd.data.parChk.fmParChk;
          cfg.cramParChk <= cmd.data.parChk.cramParChk;
          cfg.dramParChk <= cmd.data.parChk.dramParChk;
          cfg.fsChk      <= cmd.data.parChk.fsChk;
        end
        LD_MISC: begin
          cfg.mboxCycDis  <= cmd.data.misc.mboxCycDis;
          cfg.respSim     <= cmd.data.misc.respSim;
          cfg.arArxParChk <= cmd.data.misc.arArxParChk;
          cfg.errStopEn   <= cmd.data.misc.errStopEn;
        end
        default: begin
          // Codes 0 to 3 leave the configuration alone
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/clkDiagCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module clkDiagCtrl (
  input  logic                               CLK,
  input  logic                               FPGA_RESET,
  input  logic                               PSEL,
  input  logic                               PENABLE,
  input  logic                               PWRITE,
  input  logic [clkDiagPkg::APB_ADDR_W-1:0]  PADDR,
  input  logic [clkDiagPkg::APB_DATA_W-1:0]  PWDATA,
  output logic [clkDiagPkg::APB_DATA_W-1:0]  PRDATA,
  output logic                               eboxTick,
  output clkDiagPkg::runState_t              run,
  output clkDiagPkg::clkCfg_t                cfg
);

  import clkDiagPkg::*;

  diagCmd_t            cmd;
  logic [BURST_W-1:0]  count;
  logic                countZero;
  logic                burstStep;
  logic [DIAG_W-1:0]   rdWord;

  apbDiagPort u_port (
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .cmd     (cmd),
    .rdWord  (rdWord)
  );

  clkConfigRegs u_cfg (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .cmd        (cmd),
    .cfg        (cfg)
  );

  burstCounter u_burst (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .cmd        (cmd),
    .burstStep  (burstStep),
    .count      (count),
    .countZero  (countZero)
  );

  // Only the rate select reaches the gate
  eboxClkGate u_gate (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .cmd        (cmd),
    .rateSel    (cfg.rateSel),
    .countZero  (countZero),
    .run        (run),
    .burstStep  (burstStep),
    .eboxTick   (eboxTick)
  );

  diagReadMux u_rdMux (
    .sel    (cmd.sel),  // Read select follows PADDR
    .count  (count),
    .cfg    (cfg),
    .run    (run),
    .rdWord (rdWord)
  );

endmodule

`default_nettype wire

// File: hdl/clkDiagPkg.sv
`default_nettype none

package clkDiagPkg;

  // Bus and datapath widths
  localparam int APB_ADDR_W = 4;
  localparam int APB_DATA_W = 8;
  localparam int DIAG_W     = 6;   // One readback word
  localparam int BURST_W    = 8;
  localparam int SEL_W      = 3;   // Function select within a region
  localparam int NIBBLE_W   = 4;
  localparam int RATE_DIV_W = 3;   // Slowest rate is one tick in 8

  // CTL functions 00x
  // Code 4 (conditional single step) has no effect
  localparam logic [SEL_W-1:0] FN_START       = 3'd1;
  localparam logic [SEL_W-1:0] FN_SINGLE_STEP = 3'd2;
  localparam logic [SEL_W-1:0] FN_EBOX_SS     = 3'd3;
  localparam logic [SEL_W-1:0] FN_BURST       = 3'd5;
  localparam logic [SEL_W-1:0] FN_CLR_RESET   = 3'd6;
  localparam logic [SEL_W-1:0] FN_SET_RESET   = 3'd7;

  // LD functions 04x
  localparam logic [SEL_W-1:0] LD_BURST_LO = 3'd2;
  localparam logic [SEL_W-1:0] LD_BURST_HI = 3'd3;
  localparam logic [SEL_W-1:0] LD_SRC_RATE = 3'd4;
  localparam logic [SEL_W-1:0] LD_EBOX_DIS = 3'd5;
  localparam logic [SEL_W-1:0] LD_PAR_CHK  = 3'd6;
  localparam logic [SEL_W-1:0] LD_MISC     = 3'd7;

  typedef struct packed {
    logic [1:0] sourceSel;
    logic [1:0] rateSel;
  } srcRate_t;

  typedef struct packed {
    logic unused;    // MSB has no function on 045
    logic crmDis;
    logic edpDis;
    logic ctlDis;
  } eboxDis_t;

  typedef struct packed {
    logic fmParChk;
    logic cramParChk;
    logic dramParChk;
    logic fsChk;
  } parChk_t;

  typedef struct packed {
    logic mboxCycDis;
    logic respSim;
    logic arArxParChk;
    logic errStopEn;
  } misc_t;

  // One data nibble decoded per load code
  typedef union packed {
    srcRate_t              srcRate;
    eboxDis_t              eboxDis;
    parChk_t               parChk;
    misc_t                 misc;
    logic [NIBBLE_W-1:0]   nibble;
  } loadWord_u;

  typedef struct packed {
    logic             ctlWrite;
    logic             ldWrite;
    logic [SEL_W-1:0] sel;
    loadWord_u        data;
  } diagCmd_t;

  typedef struct packed {
    logic [1:0] sourceSel;
    logic [1:0] rateSel;
    logic       crmDis;
    logic       edpDis;
    logic       ctlDis;
    logic       fmParChk;
    logic       cramParChk;
    logic       dramParChk;
    logic       fsChk;
    logic       mboxCycDis;
    logic       respSim;
    logic       arArxParChk;
    logic       errStopEn;
  } clkCfg_t;

  typedef struct packed {
    logic go;
    logic burst;
    logic eboxSs;
    logic mrReset;
  } runState_t;

endpackage

`default_nettype wire

// File: hdl/diagReadMux.sv
`timescale 1ns/1ps
`default_nettype none

module diagReadMux (
  input  logic [2:0]                       sel,
  input  logic [clkDiagPkg::BURST_W-1:0]   count,
  input  clkDiagPkg::clkCfg_t              cfg,
  input  clkDiagPkg::runState_t            run,
  output logic [clkDiagPkg::DIAG_W-1:0]    rdWord
);

  always_comb begin
    case (sel)
      3'd0: rdWord = count[7:2];
      3'd1: rdWord = {count[1:0], cfg.sourceSel, cfg.rateSel};
      // Run bits read back active low as on the board
      3'd2: rdWord = {~run.go,
                      ~run.burst,
                      ~run.eboxSs,
                      run.mrReset,
                      cfg.crmDis,
                      cfg.edpDis};
      3'd3: rdWord = {cfg.ctlDis,
                      cfg.fmParChk,
                      cfg.cramParChk,
                      cfg.dramParChk,
                      cfg.fsChk,
                      cfg.mboxCycDis};
      3'd4: rdWord = {cfg.respSim,
                      cfg.arArxParChk,
                      cfg.errStopEn,
                      3'b000};
      default: rdWord = '0;  // Words 5 to 7
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/eboxClkGate.sv
`timescale 1ns/1ps
`default_nettype none

module eboxClkGate (
  input  logic                   CLK,
  input  logic                   FPGA_RESET,
  input  clkDiagPkg::diagCmd_t   cmd,
  input  logic [1:0]             rateSel,
  input  logic                   countZero,
  output clkDiagPkg::runState_t  run,
  output logic                   burstStep,
  output logic                   eboxTick
);

  import clkDiagPkg::*;

  logic [RATE_DIV_W-1:0] rateDiv;
  logic [RATE_DIV_W-1:0] rateMask;
  logic                  rateTick;
  logic                  stepPending;
  logic                  stepTick;
  logic                  tickReq;

  // Free-running rate divider
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      rateDiv <= '0;
    end else begin
      rateDiv <= rateDiv + 1'b1;
    end
  end

  assign rateMask = ~({RATE_DIV_W{1'b1}} << rateSel);  // 000, 001, 011, 111
  assign rateTick = ((rateDiv & rateMask) == '0);  // Low rateSel bits all zero

  assign burstStep = rateTick & run.burst & ~countZero;
  assign stepTick  = rateTick & stepPending;
  assign tickReq   = (rateTick & run.go) | burstStep | stepTick;

  // Every CTL function reloads go, burst and EBOX single step
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      run <= '0;
    end else if (cmd.ctlWrite) begin
      run.go     <= (cmd.sel == FN_START);
      run.burst  <= (cmd.sel == FN_BURST);
      run.eboxSs <= (cmd.sel == FN_EBOX_SS);
      if (cmd.sel == FN_SET_RESET) begin
        run.mrReset <= 1'b1;
      end else if (cmd.sel == FN_CLR_RESET) begin
        run.mrReset <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      stepPending <= 1'b0;
    end else if (cmd.ctlWrite && (cmd.sel == FN_SINGLE_STEP)) begin
      stepPending <= 1'b1;
    end else if (stepTick) begin
      stepPending <= 1'b0;  // Used up by its tick
    end
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      eboxTick <= 1'b0;
    end else begin
      eboxTick <= tickReq;  // One-cycle enable pulse
    end
  end

endmodule

`default_nettype wire

// File: sim/tbClkDiagCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module tbClkDiagCtrl;

  import clkDiagPkg::*;

  logic                  CLK;
  logic                  FPGA_RESET;
  logic                  PSEL;
  logic                  PENABLE;
  logic                  PWRITE;
  logic [APB_ADDR_W-1:0] PADDR;
  logic [APB_DATA_W-1:0] PWDATA;
  logic [APB_DATA_W-1:0] PRDATA;
  logic                  eboxTick;
  runState_t             run;
  clkCfg_t               cfg;

  int      errors;
  int      seed;
  int      totalTicks;
  clkCfg_t expCfg;  // Expected configuration from the load rules

  clkDiagCtrl u_dut (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .eboxTick(eboxTick), .run(run),
    .cfg(cfg)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    if (FPGA_RESET) totalTicks <= 0;
    else if (eboxTick) totalTicks <= totalTicks + 1;
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED at time %0t: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  // Setup and access phase of one cycle each
  task automatic apbWrite(input logic [APB_ADDR_W-1:0] addr, input logic [3:0] nibble);
    PSEL = 1'b1;
    PWRITE = 1'b1;
    PADDR = addr;
    PWDATA = {4'h0, nibble};
    @(posedge CLK);
    #0.5;
    PENABLE = 1'b1;
    @(posedge CLK);
    #0.5;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
  endtask

  task automatic apbRead(input logic [APB_ADDR_W-1:0] addr,
                         output logic [APB_DATA_W-1:0] data);
    PSEL = 1'b1;
    PWRITE = 1'b0;
    PADDR = addr;
    @(posedge CLK);
    #0.5;
    PENABLE = 1'b1;
    #1 data = PRDATA;  // Mid access phase
    @(posedge CLK);
    #0.5;
    PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic ctlFunction(input logic [2:0] fn);
    apbWrite({1'b0, fn}, 4'h0);
  endtask

  task automatic loadFunction(input logic [2:0] fn, input logic [3:0] nibble);
    apbWrite({1'b1, fn}, nibble);
  endtask

  task automatic checkWord(input logic [2:0] sel, input logic [DIAG_W-1:0] expected);
    logic [APB_DATA_W-1:0] data;
    apbRead({1'b0, sel}, data);
    checkValue($sformatf("PRDATA word %0d", sel), 32'(expected), 32'(data));
  endtask

  function automatic logic [DIAG_W-1:0] runWord(input logic go, input logic burst,
                                                input logic ss, input logic mr);
    return {~go, ~burst, ~ss, mr, expCfg.crmDis, expCfg.edpDis};  // Active-low run bits
  endfunction

  task automatic setRate(input logic [1:0] rate);
    loadFunction(LD_SRC_RATE, {2'b00, rate});
    expCfg.sourceSel = 2'b00;
    expCfg.rateSel   = rate;
  endtask

  task automatic waitTicks(input int base, input int target, input int limit);
    int cycles;
    cycles = 0;
    while ((totalTicks - base) < target && cycles < limit) begin
      @(posedge CLK);
      #0.5;
      cycles++;
    end
    if ((totalTicks - base) < target) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %0d EBOX ticks, saw %0d",
               limit, target, totalTicks - base);
    end
  endtask

  task automatic ticksOver(input int cycles, output int n);
    int base;
    base = totalTicks;
    repeat (cycles) @(posedge CLK);
    #0.5 n = totalTicks - base;
  endtask

  task automatic resetTest();
    int n;
    for (int w = 0; w < 8; w++) checkWord(3'(w), (w == 2) ? runWord(0, 0, 0, 0) : 6'h00);
    checkValue("run", 32'h0, 32'(run));
    checkValue("cfg", 32'h0, 32'(cfg));
    ticksOver(20, n);
    checkValue("eboxTick count", 32'd0, 32'(n));
  endtask

  task automatic configTest();
    logic [3:0] r[4];
    for (int i = 0; i < 4; i++) r[i] = 4'($random(seed));
    loadFunction(LD_SRC_RATE, r[0]);
    loadFunction(LD_EBOX_DIS, r[1]);
    loadFunction(LD_PAR_CHK, r[2]);
    loadFunction(LD_MISC, r[3]);
    {expCfg.sourceSel, expCfg.rateSel} = r[0];
    {expCfg.crmDis, expCfg.edpDis, expCfg.ctlDis} = r[1][2:0];  // Bit 3 unused
    {expCfg.fmParChk, expCfg.cramParChk, expCfg.dramParChk, expCfg.fsChk} = r[2];
    {expCfg.mboxCycDis, expCfg.respSim, expCfg.arArxParChk, expCfg.errStopEn} = r[3];
    checkValue("cfg", 32'(expCfg), 32'(cfg));
    checkWord(3'd1, {2'b00, r[0]});
    checkWord(3'd2, runWord(0, 0, 0, 0));
    checkWord(3'd3, {expCfg.ctlDis, r[2], expCfg.mboxCycDis});
    checkWord(3'd4, {r[3][2:0], 3'b000});
    loadFunction(3'd0, 4'($random(seed)));  // Load code 0 is ignored
    checkValue("cfg after load 0", 32'(expCfg), 32'(cfg));
    checkWord(3'd0, 6'h00);
  endtask

  task automatic startTest();
    int base;
    int n;
    setRate(2'd0);
    base = totalTicks;
    ctlFunction(FN_START);
    waitTicks(base, 1, 20);
    checkValue("run.go", 32'd1, 32'(run.go));
    checkWord(3'd2, runWord(1, 0, 0, 0));
    ticksOver(16, n);
    checkValue("eboxTick count at rate 0", 32'd16, 32'(n));
    setRate(2'd2);
    ticksOver(64, n);
    assert (n >= 15 && n <= 17) else begin
      errors++;
      $display("CHECK FAILED at time %0t: eboxTick count at rate 2 expected 16 +/- 1, got %0d",
               $time, n);
    end
    ctlFunction(FN_EBOX_SS);
    repeat (4) @(posedge CLK);  // Let a last tick drain
    #0.5 ticksOver(20, n);
    checkValue("eboxTick count after EBOX SS", 32'd0, 32'(n));
    checkWord(3'd2, runWord(0, 0, 1, 0));
  endtask

  task automatic burstTest();
    logic [7:0] len;
    int         base;
    len = 8'($random(seed));
    if (len == 8'd0) len = 8'd1;
    setRate(2'd1);
    loadFunction(LD_BURST_LO, len[3:0]);
    loadFunction(LD_BURST_HI, len[7:4]);
    checkWord(3'd0, len[7:2]);
    checkWord(3'd1, {len[1:0], 4'b0001});
    base = totalTicks;
    ctlFunction(FN_BURST);
    waitTicks(base, int'(len), 4 * int'(len) + 20);
    repeat (20) @(posedge CLK);  // No extra ticks may follow
    #0.5 checkValue("burst tick count", 32'(len), 32'(totalTicks - base));
    checkWord(3'd0, 6'h00);
    checkWord(3'd1, 6'b000001);
    checkWord(3'd2, runWord(0, 1, 0, 0));
  endtask

  task automatic singleStepTest();
    int base;
    setRate(2'd3);
    for (int i = 0; i < 3; i++) begin
      base = totalTicks;
      ctlFunction(FN_SINGLE_STEP);
      waitTicks(base, 1, 40);
      repeat (20) @(posedge CLK);
      #0.5 checkValue("single step tick count", 32'd1, 32'(totalTicks - base));
    end
  endtask

  task automatic resetBitTest();
    ctlFunction(FN_START);
    ctlFunction(FN_SET_RESET);
    checkValue("run.mrReset", 32'd1, 32'(run.mrReset));
    checkValue("run.go", 32'd0, 32'(run.go));
    checkWord(3'd2, runWord(0, 0, 0, 1));
    ctlFunction(FN_START);
    ctlFunction(FN_CLR_RESET);
    checkValue("run.mrReset", 32'd0, 32'(run.mrReset));
    checkValue("run.go", 32'd0, 32'(run.go));
    checkWord(3'd2, runWord(0, 0, 0, 0));
  endtask

  initial begin
    errors = 0;
    seed = 32'hae8e;
    expCfg = '0;
    FPGA_RESET = 1'b1;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    repeat (3) @(posedge CLK);
    #0.5 FPGA_RESET = 1'b0;
    resetTest();
    configTest();
    startTest();
    burstTest();
    singleStepTest();
    resetBitTest();
    $display("Simulation finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hdl/clkDiagPkg.sv
hdl/apbDiagPort.sv
hdl/clkConfigRegs.sv
hdl/burstCounter.sv
hdl/eboxClkGate.sv
hdl/diagReadMux.sv
hdl/clkDiagCtrl.sv
sim/tbClkDiagCtrl.sv
